/* bench/tb_axi_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem #(
   parameter logic [31:0] ERR_LO = 32'h0,
   parameter logic [31:0] ERR_HI = 32'h0
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [31:0]                seed,
   input  logic                       arvalid,
   input  logic [ifu_pkg::ADDR_W-1:0] araddr,
   output logic                       arready,
   output logic                       rvalid,
   output logic [ifu_pkg::BLK_W-1:0]  rdata,
   output logic [1:0]                 rresp
);

   import ifu_pkg::*;

   logic [ADDR_W-1:0] addr_q [$];                       // Accepted reads, oldest first
   int                due_q [$];                        // Earliest return cycle per read
   int                cycle;

   // Halfword content, low two bits pick compressed or 32-bit
   function automatic logic [PARCEL_W-1:0] parcel_at(input pc_t hw);
      logic [31:0]         h;
      logic [PARCEL_W-1:0] p;
      h       = ({1'b0, hw} * 32'h9E37_79B1) ^ seed;
      h       = h ^ (h >> 16);
      h       = h * 32'h85EB_CA6B;
      h       = h ^ (h >> 13);
      p       = h[PARCEL_W-1:0];
      p[1:0]  = h[17] ? 2'b11 : 2'b01;
      return p;
   endfunction

   initial begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rdata   = '0;
      rresp   = 2'b00;
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         cycle = 0;
         addr_q.delete();
         due_q.delete();
      end else begin
         cycle = cycle + 1;
         if (arvalid && arready) begin
            addr_q.push_back(araddr);
            due_q.push_back(cycle + int'($urandom_range(3)));  // One to four cycles
         end
      end
   end

   always @(negedge clk) begin
      logic [ADDR_W-1:0] a;
      int                i;
      arready = rst_n && ($urandom_range(99) < 75);    // Stall about one cycle in four
      rvalid  = 1'b0;
      rresp   = 2'b00;
      if (rst_n && addr_q.size() > 0 && due_q[0] <= cycle) begin
         a = addr_q.pop_front();
         void'(due_q.pop_front());
         for (i = 0; i < PARCELS; i++) begin
            rdata[PARCEL_W*i +: PARCEL_W] = parcel_at(a[ADDR_W-1:1] + pc_t'(i));
         end
         rvalid = 1'b1;
         rresp  = (a >= ERR_LO && a < ERR_HI) ? 2'b10 : 2'b00;   // SLVERR in the window
      end
   end

endmodule

`default_nettype wire

/* bench/tb_ifu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ifu;

   import ifu_pkg::*;

   localparam logic [ADDR_W-1:0] ERR_LO    = 32'h0000_1100;   // Eight faulting blocks
   localparam logic [ADDR_W-1:0] ERR_HI    = 32'h0000_1140;
   localparam logic [ADDR_W-1:0] RESET_BLK = RESET_PC & ~32'h7;
   localparam int                MAX_CYC   = 20000;
   localparam int                N_FLUSH   = 8;

   logic              clk;
   logic              rst_n;
   logic              flush;
   pc_t               flush_path;
   logic              arready;
   logic              rvalid;
   logic [BLK_W-1:0]  rdata;
   logic [1:0]        rresp;
   logic              inst_ready;
   logic              arvalid;
   logic [ADDR_W-1:0] araddr;
   logic              inst_valid;
   logic [INST_W-1:0] inst;
   pc_t               inst_pc;
   logic              inst_pc4;
   logic              inst_icaf;
   logic [31:0]       seed;
   logic              ready_random;
   logic              rst_seen;
   logic              ar_held;
   logic [ADDR_W-1:0] held_addr;
   logic              flush_open;                       // No instruction taken since flush
   pc_t               exp_pc;                           // Reference model pc
   int                cycle;
   int                accepted;
   int                ar_count;
   int                r_count;
   int                flush_hits;
   int                straddles;
   int                icaf_hits;

   ifu_top i_ifu_top (.*);

   tb_axi_mem #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) i_mem (.*);

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      stop_with_error($sformatf("FAILED at time %0d ns: %s expected %0h, actual %0h",
                                $time, name, exp, act));
   endtask

   function automatic logic [PARCEL_W-1:0] expected_parcel(input pc_t hw);
      logic [31:0]         h;
      logic [PARCEL_W-1:0] p;
      h      = ({1'b0, hw} * 32'h9E37_79B1) ^ seed;
      h      = h ^ (h >> 16);
      h      = h * 32'h85EB_CA6B;
      h      = h ^ (h >> 13);
      p      = h[PARCEL_W-1:0];
      p[1:0] = h[17] ? 2'b11 : 2'b01;
      return p;
   endfunction

   function automatic logic in_err_window(input pc_t hw);
      return ({hw, 1'b0} >= ERR_LO) && ({hw, 1'b0} < ERR_HI);
   endfunction

   task automatic next_cycle();
      @(negedge clk);
      inst_ready = ready_random && ($urandom_range(99) < 70);
   endtask

   task automatic wait_accepted(input int target);
      while (accepted < target) begin
         next_cycle();
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle >= MAX_CYC) begin
         stop_with_error($sformatf("Timeout, run still busy after %0d cycles", MAX_CYC));
      end
   end

   // **************************************************
   // Bus checks and scoreboard
   // **************************************************
   always @(posedge clk) begin
      logic [PARCEL_W-1:0] p0;
      logic [INST_W-1:0]   exp_inst;
      logic                exp_pc4;
      logic                exp_icaf;
      if (!rst_n) begin
         if (rst_seen) begin
            assert (!arvalid) else report_mismatch("arvalid", 64'(0), 64'(arvalid));
            assert (!inst_valid) else report_mismatch("inst_valid", 64'(0), 64'(inst_valid));
         end
         rst_seen = 1'b1;
         ar_held  = 1'b0;
         exp_pc   = RESET_PC[ADDR_W-1:1];
      end else begin
         if (ar_held) begin                             // Address must hold until taken
            assert (arvalid) else report_mismatch("arvalid", 64'(1), 64'(arvalid));
            assert (araddr == held_addr)
               else report_mismatch("araddr", 64'(held_addr), 64'(araddr));
         end
         ar_held   = arvalid && !arready;
         held_addr = araddr;
         if (arvalid && arready) begin
            if (ar_count == 0) begin
               assert (araddr == RESET_BLK)
                  else report_mismatch("araddr", 64'(RESET_BLK), 64'(araddr));
            end
            ar_count = ar_count + 1;
         end
         if (rvalid) begin
            r_count = r_count + 1;
         end
         assert (ar_count - r_count <= FETCH_DEPTH)
            else stop_with_error("More reads outstanding on the bus than FETCH_DEPTH");
         if (inst_valid && inst_ready) begin
            p0       = expected_parcel(exp_pc);
            exp_pc4  = (p0[1:0] == 2'b11);
            exp_icaf = in_err_window(exp_pc) | (exp_pc4 & in_err_window(exp_pc + pc_t'(1)));
            exp_inst = exp_pc4 ? {expected_parcel(exp_pc + pc_t'(1)), p0}
                               : {{PARCEL_W{1'b0}}, p0};
            if (exp_icaf) begin
               exp_inst  = '0;                          // Faulted fetch delivers no bits
               icaf_hits = icaf_hits + 1;
            end
            if (exp_pc4 && exp_pc[2:1] == 2'b11) begin
               straddles = straddles + 1;
            end
            if (flush_open) begin                       // First one after a flush
               flush_hits = flush_hits + 1;
               flush_open = 1'b0;
            end
            assert (inst_pc == exp_pc) else report_mismatch("inst_pc", 64'(exp_pc), 64'(inst_pc));
            assert (inst_pc4 == exp_pc4)
               else report_mismatch("inst_pc4", 64'(exp_pc4), 64'(inst_pc4));
            assert (inst_icaf == exp_icaf)
               else report_mismatch("inst_icaf", 64'(exp_icaf), 64'(inst_icaf));
            assert (inst == exp_inst) else report_mismatch("inst", 64'(exp_inst), 64'(inst));
            exp_pc   = exp_pc + (exp_pc4 ? pc_t'(2) : pc_t'(1));
            accepted = accepted + 1;
         end
         if (flush) begin                               // Model restarts at the target
            exp_pc     = flush_path;
            flush_open = 1'b1;
         end
      end
   end

   // **************************************************
   // Stimulus
   // **************************************************
   initial begin
      int                i;
      logic [ADDR_W-1:0] target;
      seed         = $urandom(3);
      rst_n        = 1'b0;
      flush        = 1'b0;
      flush_path   = '0;
      inst_ready   = 1'b0;
      ready_random = 1'b0;
      repeat (16) @(posedge clk);
      next_cycle();
      rst_n        = 1'b1;
      ready_random = 1'b1;
      wait_accepted(300);                               // Runs through the error window
      ready_random = 1'b0;                              // Decode stalls, buffers fill
      inst_ready   = 1'b0;
      repeat (40) next_cycle();
      ready_random = 1'b1;
      wait_accepted(accepted + 60);
      for (i = 0; i < N_FLUSH; i++) begin
         repeat ($urandom_range(3)) next_cycle();
         while (ar_count == r_count) begin
            next_cycle();
         end
         target = 32'h0000_2000 + 32'($urandom_range(255)) * 32'd8 + ((i % 2 == 0) ? 2 : 6);
         if (i == 2) target = ERR_LO + 32'd14;          // Odd parcels near the window
         if (i == 5) target = ERR_LO - 32'd2;
         if (i == 6) target = ERR_HI - 32'd2;
         flush      = 1'b1;
         flush_path = target[ADDR_W-1:1];
         next_cycle();
         flush      = 1'b0;
         wait_accepted(accepted + 20);
      end
      next_cycle();
      if (flush_hits == N_FLUSH && straddles > 0 && icaf_hits > 0) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         stop_with_error("Stimulus missed a flush, a straddling instruction or a bus error");
      end
   end

endmodule

`default_nettype wire

/* compile.f */
logic/ifu_pkg.sv
logic/ifu_fifo.sv
logic/ifu_fetch_ctl.sv
logic/ifu_bus_rd.sv
logic/ifu_aligner.sv
logic/ifu_top.sv
bench/tb_axi_mem.sv
bench/tb_ifu.sv

/* logic/ifu_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_aligner (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                flush,
   input  ifu_pkg::pc_t        flush_path,
   input  logic                fb_empty,
   input  ifu_pkg::fetch_blk_t fb_blk,
   input  logic                iq_full,
   output logic                fb_pop,
   output logic                iq_push,
   output ifu_pkg::inst_pkt_t  iq_pkt
);

   import ifu_pkg::*;

   // **************************************************
   // Aligner state
   // **************************************************
   pc_t                 pc_a;                            // Pc of the next instruction
   logic                carry_vld;                       // Low half of a straddler held
   logic [PARCEL_W-1:0] carry_parcel;
   logic                carry_err;

   logic [PIDX_W-1:0]   idx;
   logic [PIDX_W-1:0]   idx_nxt;
   logic                last_parcel;
   logic [PARCEL_W-1:0] head_parcel;
   logic [PARCEL_W-1:0] next_parcel;
   logic [PARCEL_W-1:0] lo_parcel;
   logic [PARCEL_W-1:0] hi_parcel;
   logic                is_rvc;
   logic                inst_err;
   logic                take_carry;
   pc_t                 pc_nxt;

   // F2 parcel select from the head block
   assign idx         = pc_a[PIDX_W:1];
   assign idx_nxt     = idx + 1'b1;
   assign last_parcel = (idx == PIDX_W'(PARCELS - 1));
   assign head_parcel = fb_blk.data[PARCEL_W*idx +: PARCEL_W];
   assign next_parcel = fb_blk.data[PARCEL_W*idx_nxt +: PARCEL_W];

   always_comb begin
      fb_pop     = 1'b0;
      iq_push    = 1'b0;
      take_carry = 1'b0;
      pc_nxt     = pc_a;
      if (carry_vld) begin
         lo_parcel = carry_parcel;
         hi_parcel = fb_blk.data[PARCEL_W-1:0];          // Upper half is parcel 0
         inst_err  = carry_err | fb_blk.err;
      end else begin
         lo_parcel = head_parcel;
         hi_parcel = next_parcel;
         inst_err  = fb_blk.err;
      end
      is_rvc = (lo_parcel[1:0] != 2'b11);

      if (!fb_empty) begin
         if (!carry_vld && !is_rvc && last_parcel) begin
            // Straddler, park the low half and free the block
            take_carry = 1'b1;
            fb_pop     = 1'b1;
         end else if (!iq_full) begin
            iq_push = 1'b1;
            pc_nxt  = pc_a + pc_t'(is_rvc ? 1 : 2);
            if (is_rvc) begin
               fb_pop = last_parcel;
            end else begin
               fb_pop = !carry_vld && (idx_nxt == PIDX_W'(PARCELS - 1));
            end
         end
      end
   end

   // **************************************************
   // Packet build
   // **************************************************
   always_comb begin
      if (inst_err) begin
         iq_pkt.inst = '0;                               // Faulted fetch carries no bits
      end else if (is_rvc) begin
         iq_pkt.inst = {{PARCEL_W{1'b0}}, lo_parcel};
      end else begin
         iq_pkt.inst = {hi_parcel, lo_parcel};
      end
      iq_pkt.pc   = pc_a;
      iq_pkt.pc4  = ~is_rvc;
      iq_pkt.icaf = inst_err;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_a      <= RESET_PC[ADDR_W-1:1];
         carry_vld <= 1'b0;
      end else if (flush) begin
         pc_a      <= flush_path;                        // Start mid-block if need be
         carry_vld <= 1'b0;
      end else begin
         pc_a <= pc_nxt;
         if (take_carry) begin
            carry_vld <= 1'b1;
         end else if (iq_push) begin
            carry_vld <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_carry) begin
         carry_parcel <= head_parcel;
         carry_err    <= fb_blk.err;
      end
   end

endmodule

`default_nettype wire

/* logic/ifu_bus_rd.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_bus_rd (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       flush,
   input  logic                       req_valid,
   input  ifu_pkg::pc_t               req_pc,
   input  logic                       arready,
   input  logic                       rvalid,
   input  logic [ifu_pkg::BLK_W-1:0]  rdata,
   input  logic [1:0]                 rresp,
   output logic                       req_ready,
   output logic                       arvalid,
   output logic [ifu_pkg::ADDR_W-1:0] araddr,
   output logic [ifu_pkg::CNT_W-1:0]  bus_pending,
   output logic                       fb_push,
   output ifu_pkg::fetch_blk_t        fb_blk
);

   import ifu_pkg::*;

   logic             req_xfer;
   logic [CNT_W-1:0] pending_nxt;
   logic [CNT_W-1:0] discard_cnt;                       // Old-path beats still to come
   logic             discard;

   assign req_ready = ~arvalid;                          // One address on the bus at a time
   assign req_xfer  = req_valid & req_ready;
   assign discard   = (discard_cnt != '0);

   // Pending ar counts as outstanding from the cycle it is taken
   assign pending_nxt = bus_pending + CNT_W'(req_xfer) - CNT_W'(rvalid);

   // **************************************************
   // Read address channel and counters
   // **************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         arvalid     <= 1'b0;
         bus_pending <= '0;
         discard_cnt <= '0;
      end else begin
         bus_pending <= pending_nxt;
         if (req_xfer) begin
            arvalid <= 1'b1;
         end else if (arready) begin
            arvalid <= 1'b0;                             // Held until the slave takes it
         end
         // A beat in the flush cycle is lost with the buffer clear
         if (flush) begin
            discard_cnt <= pending_nxt;
         end else if (rvalid && discard) begin
            discard_cnt <= discard_cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_xfer) begin
         araddr <= {req_pc[ADDR_W-1:BLK_OFS], {BLK_OFS{1'b0}}};
      end
   end

   // **************************************************
   // Read data channel
   // **************************************************
   assign fb_push     = rvalid & ~discard;
   assign fb_blk.data = rdata;
   assign fb_blk.err  = |rresp;                          // SLVERR and DECERR alike

endmodule

`default_nettype wire

/* logic/ifu_fetch_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_ctl (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      flush,
   input  ifu_pkg::pc_t              flush_path,
   input  logic                      req_ready,
   input  logic [ifu_pkg::CNT_W-1:0] bus_pending,
   input  logic [ifu_pkg::CNT_W-1:0] fb_count,
   output logic                      req_valid,
   output ifu_pkg::pc_t              req_pc
);

   import ifu_pkg::*;

   pc_t            fetch_addr_bf;                       // May sit mid-block after a flush
   pc_t            next_blk_bf;
   logic           fetch_en;
   logic [CNT_W:0] credit_used;
   logic           credit_ok;
   logic           req_xfer;

   // **************************************************
   // Credit check
   // **************************************************
   // Blocks on the bus plus blocks waiting in the fetch buffer
   assign credit_used = {1'b0, bus_pending} + {1'b0, fb_count};
   assign credit_ok   = (credit_used < (CNT_W+1)'(FETCH_DEPTH));

   assign req_valid = fetch_en & credit_ok & ~flush;
   assign req_pc    = fetch_addr_bf;                     // Requester drops the block offset
   assign req_xfer  = req_valid & req_ready;

   // Next block boundary, offset bits cleared
   assign next_blk_bf = {fetch_addr_bf[ADDR_W-1:BLK_OFS] + 1'b1, {(BLK_OFS-1){1'b0}}};

   // **************************************************
   // BF address register
   // **************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fetch_en      <= 1'b0;
         fetch_addr_bf <= RESET_PC[ADDR_W-1:1];
      end else begin
         fetch_en <= 1'b1;                               // Start fetching once out of reset
         if (flush) begin
            fetch_addr_bf <= flush_path;
         end else if (req_xfer) begin
            fetch_addr_bf <= next_blk_bf;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/ifu_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_fifo #(
   parameter type data_t = logic,
   parameter int  DEPTH  = 4
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       clear,
   input  logic                       push,
   input  data_t                      push_data,
   input  logic                       pop,
   output data_t                      pop_data,
   output logic                       empty,
   output logic                       full,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   data_t            mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;   // Wrap for any depth
   endfunction

   assign empty    = (count == '0);
   assign full     = (count == CNT_W'(DEPTH));
   assign do_pop   = pop & ~empty;
   assign do_push  = push & (~full | do_pop);            // Full queue takes a push with a pop
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

endmodule

`default_nettype wire

/* logic/ifu_pkg.sv */
`default_nettype none

package ifu_pkg;

   // **************************************************
   // Widths and depths
   // **************************************************
   localparam int ADDR_W      = 32;                      // Byte address
   localparam int BLK_W       = 64;                      // One AXI beat
   localparam int PARCEL_W    = 16;
   localparam int PARCELS     = BLK_W / PARCEL_W;        // Parcels per block
   localparam int PIDX_W      = $clog2(PARCELS);         // Parcel index in a pc
   localparam int BLK_OFS     = $clog2(BLK_W / 8);       // Byte offset bits of a block
   localparam int INST_W      = 2 * PARCEL_W;
   localparam int FETCH_DEPTH = 4;                       // Blocks in flight or buffered
   localparam int IQ_DEPTH    = 4;
   localparam int CNT_W       = $clog2(FETCH_DEPTH + 1);

   localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000;

   // Halfword address, bit 0 is always zero and not carried
   typedef logic [ADDR_W-1:1] pc_t;

   // **************************************************
   // Payloads of the two queues
   // **************************************************
   typedef struct packed {
      logic [BLK_W-1:0] data;
      logic             err;                             // Bus error on this beat
   } fetch_blk_t;

   typedef struct packed {
      logic [INST_W-1:0] inst;                           // Compressed sits in low half
      pc_t               pc;
      logic              pc4;                            // 32-bit instruction
      logic              icaf;                           // Access fault
   } inst_pkt_t;

endpackage

`default_nettype wire

/* logic/ifu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       flush,
   input  ifu_pkg::pc_t               flush_path,
   input  logic                       arready,
   input  logic                       rvalid,
   input  logic [ifu_pkg::BLK_W-1:0]  rdata,
   input  logic [1:0]                 rresp,
   input  logic                       inst_ready,
   output logic                       arvalid,
   output logic [ifu_pkg::ADDR_W-1:0] araddr,
   output logic                       inst_valid,
   output logic [ifu_pkg::INST_W-1:0] inst,
   output ifu_pkg::pc_t               inst_pc,
   output logic                       inst_pc4,
   output logic                       inst_icaf
);

   import ifu_pkg::*;

   logic             req_valid;
   logic             req_ready;
   pc_t              req_pc;
   logic [CNT_W-1:0] bus_pending;
   logic [CNT_W-1:0] fb_count;
   logic             fb_push;
   logic             fb_pop;
   logic             fb_empty;
   fetch_blk_t       fb_in;
   fetch_blk_t       fb_head;
   logic             iq_push;
   logic             iq_pop;
   logic             iq_full;
   logic             iq_empty;
   inst_pkt_t        iq_in;
   inst_pkt_t        iq_head;

   // **************************************************
   // BF -> F1 -> F2 -> aligner
   // **************************************************
   ifu_fetch_ctl i_fetch_ctl (
      .clk(clk), .rst_n(rst_n), .flush(flush), .flush_path(flush_path),
      .req_ready(req_ready), .bus_pending(bus_pending), .fb_count(fb_count),
      .req_valid(req_valid), .req_pc(req_pc)
   );

   ifu_bus_rd i_bus_rd (
      .clk(clk), .rst_n(rst_n), .flush(flush), .req_valid(req_valid), .req_pc(req_pc),
      .arready(arready), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
      .req_ready(req_ready), .arvalid(arvalid), .araddr(araddr),
      .bus_pending(bus_pending), .fb_push(fb_push), .fb_blk(fb_in)
   );

   ifu_fifo #(.data_t(fetch_blk_t), .DEPTH(FETCH_DEPTH)) fetch_buf (
      .clk(clk), .rst_n(rst_n), .clear(flush), .push(fb_push), .push_data(fb_in),
      .pop(fb_pop), .pop_data(fb_head), .empty(fb_empty), .full(), .count(fb_count)
   );

   ifu_aligner i_aligner (
      .clk(clk), .rst_n(rst_n), .flush(flush), .flush_path(flush_path),
      .fb_empty(fb_empty), .fb_blk(fb_head), .iq_full(iq_full),
      .fb_pop(fb_pop), .iq_push(iq_push), .iq_pkt(iq_in)
   );

   ifu_fifo #(.data_t(inst_pkt_t), .DEPTH(IQ_DEPTH)) inst_q (
      .clk(clk), .rst_n(rst_n), .clear(flush), .push(iq_push), .push_data(iq_in),
      .pop(iq_pop), .pop_data(iq_head), .empty(iq_empty), .full(iq_full), .count()
   );

   // Decode side of the instruction queue
   assign inst_valid = ~iq_empty;
   assign iq_pop     = inst_valid & inst_ready;
   assign inst       = iq_head.inst;
   assign inst_pc    = iq_head.pc;
   assign inst_pc4   = iq_head.pc4;
   assign inst_icaf  = iq_head.icaf;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the IFU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ifu -f compile.f
out=$(./obj_dir/Vtb_ifu 2>&1) || true
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'
